// ==== sa_ctrl_pkg.sv ====
`default_nettype none

package sa_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int OPCODE_W      = 4;
    localparam int OFFMEM_ADDR_W = 32;
    localparam int UB_ADDR_W     = 8;
    localparam int ACC_ADDR_W    = 6;
    localparam int DATA_W        = 128;
    localparam int INST_W        = OPCODE_W + 2 * OFFMEM_ADDR_W;

    // Instruction layout, opcode on top and read address at the bottom
    localparam int ADDRB_LSB  = 0;
    localparam int ADDRA_LSB  = ADDRB_LSB + OFFMEM_ADDR_W;
    localparam int OPCODE_LSB = ADDRA_LSB + OFFMEM_ADDR_W;

    typedef logic [INST_W-1:0]        inst_t;
    typedef logic [OFFMEM_ADDR_W-1:0] offmem_addr_t;
    typedef logic [UB_ADDR_W-1:0]     ub_addr_t;
    typedef logic [ACC_ADDR_W-1:0]    acc_addr_t;
    typedef logic [DATA_W-1:0]        data_t;

    // Step within one instruction
    typedef logic [1:0] step_t;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Codes 2, 4 and 6 (old weight path) and 11..15 run as no-ops
    typedef enum logic [OPCODE_W-1:0] {
        IDLE            = 4'h0,
        DATA_FIFO       = 4'h1,
        AXI_TO_UB       = 4'h3,
        UB_TO_DATA_FIFO = 4'h5,
        MAT_MUL         = 4'h7,
        MAT_MUL_ACC     = 4'h8,
        ACC_TO_UB       = 4'h9,
        UB_TO_AXI       = 4'ha
    } opcode_e;

    // Off-chip engine mode
    typedef enum logic [1:0] {
        AXI_IDLE  = 2'b00,
        AXI_LOAD  = 2'b01,
        AXI_WRITE = 2'b10
    } axi_mode_e;

endpackage

`default_nettype wire

// ==== cu_step_if.sv ====
`default_nettype none

// Current instruction and step, from the sequencer to both controllers
interface cu_step_if import sa_ctrl_pkg::*; (
    input logic clk,
    input logic reset_n
);

    opcode_e      opcode;
    offmem_addr_t addra;
    offmem_addr_t addrb;
    step_t        step;
    // Instruction running and not yet done
    logic         busy;

    modport seq (output opcode, output addra, output addrb, output step, output busy);

    modport op (
        input clk, input reset_n,
        input opcode, input addra, input addrb, input step, input busy
    );

endinterface

`default_nettype wire

// ==== cu_ctrl_if.sv ====
`default_nettype none

// One controller's outputs and step verdict, towards the merge stage
interface cu_ctrl_if import sa_ctrl_pkg::*; (
    input logic clk,
    input logic reset_n
);

    logic         read_ub;
    logic         write_ub;
    logic         read_acc;
    logic         write_acc;
    logic         data_fifo_en;
    logic         mm_en;
    logic         acc_en;
    axi_mode_e    axi_mode;
    logic         init_txn_pulse;
    ub_addr_t     ub_addra;
    ub_addr_t     ub_addrb;
    acc_addr_t    acc_addra;
    acc_addr_t    acc_addrb;
    offmem_addr_t offmem_addra;
    offmem_addr_t offmem_addrb;
    data_t        dout;
    // Step counter may move on
    logic         advance;
    // Instruction completes at the end of this cycle
    logic         last;

    modport ctrl (
        output read_ub, write_ub, read_acc, write_acc, data_fifo_en, mm_en, acc_en,
        output axi_mode, init_txn_pulse,
        output ub_addra, ub_addrb, acc_addra, acc_addrb, offmem_addra, offmem_addrb,
        output dout, advance, last
    );

    modport merge (
        input clk, reset_n,
        input read_ub, write_ub, read_acc, write_acc, data_fifo_en, mm_en, acc_en,
        input axi_mode, init_txn_pulse,
        input ub_addra, ub_addrb, acc_addra, acc_addrb, offmem_addra, offmem_addrb,
        input dout, advance, last
    );

endinterface

`default_nettype wire

// ==== inst_sequencer.sv ====
`default_nettype none

module inst_sequencer import sa_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  inst_t     instruction,
    input  logic      init_inst_pulse,
    input  logic      advance,
    input  logic      last,
    cu_step_if.seq    step_bus,
    output logic      inst_done,
    output logic      idle_flag
);

    logic         pulse_q;
    logic         start;
    logic         running_q;
    logic         done_q;
    opcode_e      opcode_q;
    step_t        step_q;
    offmem_addr_t addra_q;
    offmem_addr_t addrb_q;

    // Rising edge of the start pulse
    assign start = init_inst_pulse & ~pulse_q;

    //////////////////////////////////////////////////////////////////////
    // Step state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pulse_q   <= 1'b0;
            running_q <= 1'b0;
            done_q    <= 1'b0;
            opcode_q  <= IDLE;
            step_q    <= '0;
        end else begin
            pulse_q <= init_inst_pulse;
            if (start) begin
                // New edge wins, even over a running instruction
                running_q <= 1'b1;
                done_q    <= 1'b0;
                opcode_q  <= opcode_e'(instruction[OPCODE_LSB +: OPCODE_W]);
                step_q    <= '0;
            end else if (last) begin
                done_q <= 1'b1;
            end else if (advance) begin
                step_q <= step_q + 2'd1;
            end
        end
    end

    // Addresses are payload only
    always_ff @(posedge clk) begin
        if (start) begin
            addra_q <= instruction[ADDRA_LSB +: OFFMEM_ADDR_W];
            addrb_q <= instruction[ADDRB_LSB +: OFFMEM_ADDR_W];
        end
    end

    assign step_bus.opcode = opcode_q;
    assign step_bus.addra  = addra_q;
    assign step_bus.addrb  = addrb_q;
    assign step_bus.step   = step_q;
    assign step_bus.busy   = running_q & ~done_q;

    assign inst_done = done_q;
    assign idle_flag = (opcode_q == IDLE) || done_q;

    // Controllers must go quiet once the instruction is done
    a_step_frozen: assert property (@(posedge clk) disable iff (!reset_n)
        done_q && !start |=> step_q == $past(step_q));

endmodule

`default_nettype wire

// ==== local_op_ctrl.sv ====
`default_nettype none

module local_op_ctrl import sa_ctrl_pkg::*; (
    cu_step_if.op    step_bus,
    input  data_t    rin,
    cu_ctrl_if.ctrl  out_bus
);

    always_comb begin
        out_bus.read_ub        = 1'b0;
        out_bus.write_ub       = 1'b0;
        out_bus.read_acc       = 1'b0;
        out_bus.write_acc      = 1'b0;
        out_bus.data_fifo_en   = 1'b0;
        out_bus.mm_en          = 1'b0;
        out_bus.acc_en         = 1'b0;
        out_bus.axi_mode       = AXI_IDLE;
        out_bus.init_txn_pulse = 1'b0;
        out_bus.ub_addra       = '0;
        out_bus.ub_addrb       = '0;
        out_bus.acc_addra      = '0;
        out_bus.acc_addrb      = '0;
        out_bus.offmem_addra   = '0;
        out_bus.offmem_addrb   = '0;
        out_bus.dout           = '0;
        out_bus.advance        = 1'b0;
        out_bus.last           = 1'b0;

        if (step_bus.busy) begin
            case (step_bus.opcode)
                AXI_TO_UB, UB_TO_AXI: begin
                    // Off-chip transfers, not ours
                end
                DATA_FIFO: begin
                    out_bus.data_fifo_en = 1'b1;
                    out_bus.advance      = 1'b1;
                    out_bus.last         = 1'b1;
                end
                UB_TO_DATA_FIFO: begin
                    out_bus.read_ub      = 1'b1;
                    out_bus.data_fifo_en = 1'b1;
                    out_bus.ub_addrb     = step_bus.addrb[UB_ADDR_W-1:0];
                    out_bus.advance      = 1'b1;
                    out_bus.last         = 1'b1;
                end
                MAT_MUL, MAT_MUL_ACC: begin
                    out_bus.acc_en  = (step_bus.opcode == MAT_MUL_ACC);
                    out_bus.advance = 1'b1;
                    if (step_bus.step == 2'd0) begin
                        // Fetch the input row
                        out_bus.read_ub  = 1'b1;
                        out_bus.ub_addrb = step_bus.addrb[UB_ADDR_W-1:0];
                    end else begin
                        out_bus.write_acc    = 1'b1;
                        out_bus.data_fifo_en = 1'b1;
                        out_bus.mm_en        = 1'b1;
                        out_bus.acc_addra    = step_bus.addra[ACC_ADDR_W-1:0];
                        out_bus.last         = 1'b1;
                    end
                end
                ACC_TO_UB: begin
                    out_bus.advance = 1'b1;
                    if (step_bus.step == 2'd0) begin
                        out_bus.read_acc  = 1'b1;
                        out_bus.acc_addrb = step_bus.addrb[ACC_ADDR_W-1:0];
                    end else begin
                        // Result word goes back into the buffer
                        out_bus.write_ub = 1'b1;
                        out_bus.ub_addra = step_bus.addra[UB_ADDR_W-1:0];
                        out_bus.dout     = rin;
                        out_bus.last     = 1'b1;
                    end
                end
                default: begin
                    // IDLE and unused codes, done after one cycle
                    out_bus.advance = 1'b1;
                    out_bus.last    = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== offmem_xfer_ctrl.sv ====
`default_nettype none

module offmem_xfer_ctrl import sa_ctrl_pkg::*; (
    cu_step_if.op    step_bus,
    input  logic     txn_done,
    input  data_t    din,
    input  data_t    uin,
    cu_ctrl_if.ctrl  out_bus
);

    always_comb begin
        out_bus.read_ub        = 1'b0;
        out_bus.write_ub       = 1'b0;
        out_bus.read_acc       = 1'b0;
        out_bus.write_acc      = 1'b0;
        out_bus.data_fifo_en   = 1'b0;
        out_bus.mm_en          = 1'b0;
        out_bus.acc_en         = 1'b0;
        out_bus.axi_mode       = AXI_IDLE;
        out_bus.init_txn_pulse = 1'b0;
        out_bus.ub_addra       = '0;
        out_bus.ub_addrb       = '0;
        out_bus.acc_addra      = '0;
        out_bus.acc_addrb      = '0;
        out_bus.offmem_addra   = '0;
        out_bus.offmem_addrb   = '0;
        out_bus.dout           = '0;
        out_bus.advance        = 1'b0;
        out_bus.last           = 1'b0;

        if (step_bus.busy) begin
            case (step_bus.opcode)
                AXI_TO_UB: begin
                    out_bus.axi_mode     = AXI_LOAD;
                    out_bus.offmem_addrb = step_bus.addrb;
                    if (step_bus.step == 2'd0) begin
                        // Kick off the load
                        out_bus.init_txn_pulse = 1'b1;
                        out_bus.advance        = 1'b1;
                    end else if (txn_done) begin
                        out_bus.write_ub = 1'b1;
                        out_bus.ub_addra = step_bus.addra[UB_ADDR_W-1:0];
                        out_bus.dout     = din;
                        out_bus.advance  = 1'b1;
                        out_bus.last     = 1'b1;
                    end
                end
                UB_TO_AXI: begin
                    if (step_bus.step == 2'd0) begin
                        out_bus.read_ub  = 1'b1;
                        out_bus.ub_addrb = step_bus.addrb[UB_ADDR_W-1:0];
                        out_bus.advance  = 1'b1;
                    end else begin
                        // Write word held until the engine reports back
                        out_bus.axi_mode       = AXI_WRITE;
                        out_bus.offmem_addra   = step_bus.addra;
                        out_bus.dout           = uin;
                        out_bus.init_txn_pulse = (step_bus.step == 2'd1);
                        out_bus.advance        = (step_bus.step == 2'd1) || txn_done;
                        out_bus.last           = (step_bus.step == 2'd2) && txn_done;
                    end
                end
                default: begin
                    // Local operations
                end
            endcase
        end
    end

    // Pulse step must always be left after one cycle
    a_txn_pulse_single: assert property (
        @(posedge step_bus.clk) disable iff (!step_bus.reset_n)
        out_bus.init_txn_pulse |=> !out_bus.init_txn_pulse);

endmodule

`default_nettype wire

// ==== cu_output_merge.sv ====
`default_nettype none

module cu_output_merge import sa_ctrl_pkg::*; (
    cu_ctrl_if.merge     local_bus,
    cu_ctrl_if.merge     xfer_bus,
    output logic         advance,
    output logic         last,
    output axi_mode_e    axi_sm_mode,
    output logic         init_txn_pulse,
    output logic         read_ub,
    output logic         write_ub,
    output logic         read_acc,
    output logic         write_acc,
    output logic         data_fifo_en,
    output logic         mm_en,
    output logic         acc_en,
    output ub_addr_t     ub_addra,
    output ub_addr_t     ub_addrb,
    output acc_addr_t    acc_addra,
    output acc_addr_t    acc_addrb,
    output offmem_addr_t offmem_addra,
    output offmem_addr_t offmem_addrb,
    output data_t        dout
);

    // An idle controller drives zeros, so OR is enough
    assign read_ub        = local_bus.read_ub        | xfer_bus.read_ub;
    assign write_ub       = local_bus.write_ub       | xfer_bus.write_ub;
    assign read_acc       = local_bus.read_acc       | xfer_bus.read_acc;
    assign write_acc      = local_bus.write_acc      | xfer_bus.write_acc;
    assign data_fifo_en   = local_bus.data_fifo_en   | xfer_bus.data_fifo_en;
    assign mm_en          = local_bus.mm_en          | xfer_bus.mm_en;
    assign acc_en         = local_bus.acc_en         | xfer_bus.acc_en;
    assign init_txn_pulse = local_bus.init_txn_pulse | xfer_bus.init_txn_pulse;
    assign ub_addra       = local_bus.ub_addra       | xfer_bus.ub_addra;
    assign ub_addrb       = local_bus.ub_addrb       | xfer_bus.ub_addrb;
    assign acc_addra      = local_bus.acc_addra      | xfer_bus.acc_addra;
    assign acc_addrb      = local_bus.acc_addrb      | xfer_bus.acc_addrb;
    assign offmem_addra   = local_bus.offmem_addra   | xfer_bus.offmem_addra;
    assign offmem_addrb   = local_bus.offmem_addrb   | xfer_bus.offmem_addrb;
    assign dout           = local_bus.dout           | xfer_bus.dout;

    // Engine mode only comes from the transfer side
    assign axi_sm_mode = xfer_bus.axi_mode;

    // Step verdict for the sequencer
    assign advance = local_bus.advance | xfer_bus.advance;
    assign last    = local_bus.last    | xfer_bus.last;

    // Opcode ownership is exclusive between the controllers
    a_single_owner: assert property (
        @(posedge local_bus.clk) disable iff (!local_bus.reset_n)
        !(local_bus.advance && xfer_bus.advance));

endmodule

`default_nettype wire

// ==== sa_control_unit.sv ====
`default_nettype none

module sa_control_unit import sa_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  inst_t        instruction,
    input  logic         init_inst_pulse,
    input  logic         txn_done,
    input  data_t        din,
    input  data_t        rin,
    input  data_t        uin,
    output axi_mode_e    axi_sm_mode,
    output logic         init_txn_pulse,
    output logic         inst_done,
    output logic         idle_flag,
    output logic         read_ub,
    output logic         write_ub,
    output logic         read_acc,
    output logic         write_acc,
    output logic         data_fifo_en,
    output logic         mm_en,
    output logic         acc_en,
    output ub_addr_t     ub_addra,
    output ub_addr_t     ub_addrb,
    output acc_addr_t    acc_addra,
    output acc_addr_t    acc_addrb,
    output offmem_addr_t offmem_addra,
    output offmem_addr_t offmem_addrb,
    output data_t        dout
);

    logic advance;
    logic last;

    cu_step_if step_bus  (.clk(clk), .reset_n(reset_n));
    cu_ctrl_if local_bus (.clk(clk), .reset_n(reset_n));
    cu_ctrl_if xfer_bus  (.clk(clk), .reset_n(reset_n));

    inst_sequencer u_inst_sequencer (
        .clk             (clk),
        .reset_n         (reset_n),
        .instruction     (instruction),
        .init_inst_pulse (init_inst_pulse),
        .advance         (advance),
        .last            (last),
        .step_bus        (step_bus),
        .inst_done       (inst_done),
        .idle_flag       (idle_flag)
    );

    ////////////////////////////////////////////////////////////////////////
    // Controllers working side by side
    ////////////////////////////////////////////////////////////////////////

    local_op_ctrl u_local_op_ctrl (
        .step_bus (step_bus),
        .rin      (rin),
        .out_bus  (local_bus)
    );

    offmem_xfer_ctrl u_offmem_xfer_ctrl (
        .step_bus (step_bus),
        .txn_done (txn_done),
        .din      (din),
        .uin      (uin),
        .out_bus  (xfer_bus)
    );

    cu_output_merge u_cu_output_merge (
        .local_bus      (local_bus),
        .xfer_bus       (xfer_bus),
        .advance        (advance),
        .last           (last),
        .axi_sm_mode    (axi_sm_mode),
        .init_txn_pulse (init_txn_pulse),
        .read_ub        (read_ub),
        .write_ub       (write_ub),
        .read_acc       (read_acc),
        .write_acc      (write_acc),
        .data_fifo_en   (data_fifo_en),
        .mm_en          (mm_en),
        .acc_en         (acc_en),
        .ub_addra       (ub_addra),
        .ub_addrb       (ub_addrb),
        .acc_addra      (acc_addra),
        .acc_addrb      (acc_addrb),
        .offmem_addra   (offmem_addra),
        .offmem_addrb   (offmem_addrb),
        .dout           (dout)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

// Free running clock for the testbench, period of 4 time units
module tb_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== sa_control_unit_tb.sv ====
`default_nettype none

module sa_control_unit_tb import sa_ctrl_pkg::*; ();

    localparam int NUM_TESTS       = 300;
    localparam int TXN_MAX_DELAY   = 6;
    // Longest instruction is UB_TO_AXI, well inside TXN_MAX_DELAY + 8 cycles
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (TXN_MAX_DELAY + 8) + 16;

    // Bit positions in the enable vector
    localparam int EN_READ_UB   = 6;
    localparam int EN_WRITE_UB  = 5;
    localparam int EN_READ_ACC  = 4;
    localparam int EN_WRITE_ACC = 3;
    localparam int EN_FIFO      = 2;
    localparam int EN_MM        = 1;
    localparam int EN_ACC       = 0;

    logic         clk;
    logic         reset_n;
    inst_t        instruction;
    logic         init_inst_pulse;
    logic         txn_done;
    data_t        din;
    data_t        rin;
    data_t        uin;
    axi_mode_e    axi_sm_mode;
    logic         init_txn_pulse;
    logic         inst_done;
    logic         idle_flag;
    logic         read_ub;
    logic         write_ub;
    logic         read_acc;
    logic         write_acc;
    logic         data_fifo_en;
    logic         mm_en;
    logic         acc_en;
    ub_addr_t     ub_addra;
    ub_addr_t     ub_addrb;
    acc_addr_t    acc_addra;
    acc_addr_t    acc_addrb;
    offmem_addr_t offmem_addra;
    offmem_addr_t offmem_addrb;
    data_t        dout;
    logic [6:0]   act_en;

    // Reference model state
    logic [6:0]   exp_en;
    logic         exp_pulse;
    logic         exp_done;
    logic         exp_idle;
    axi_mode_e    exp_mode;
    ub_addr_t     exp_ub_addra;
    ub_addr_t     exp_ub_addrb;
    acc_addr_t    exp_acc_addra;
    acc_addr_t    exp_acc_addrb;
    offmem_addr_t exp_offmem_addra;
    offmem_addr_t exp_offmem_addrb;
    data_t        exp_dout;

    offmem_addr_t cur_addra;
    offmem_addr_t cur_addrb;
    data_t        cur_din;
    data_t        cur_rin;
    data_t        cur_uin;

    integer       seed;
    int           pass_count;
    int           fail_count;
    int           test_errors;

    tb_clk_gen u_tb_clk_gen (.clk(clk));

    sa_control_unit u_sa_control_unit (
        .clk             (clk),
        .reset_n         (reset_n),
        .instruction     (instruction),
        .init_inst_pulse (init_inst_pulse),
        .txn_done        (txn_done),
        .din             (din),
        .rin             (rin),
        .uin             (uin),
        .axi_sm_mode     (axi_sm_mode),
        .init_txn_pulse  (init_txn_pulse),
        .inst_done       (inst_done),
        .idle_flag       (idle_flag),
        .read_ub         (read_ub),
        .write_ub        (write_ub),
        .read_acc        (read_acc),
        .write_acc       (write_acc),
        .data_fifo_en    (data_fifo_en),
        .mm_en           (mm_en),
        .acc_en          (acc_en),
        .ub_addra        (ub_addra),
        .ub_addrb        (ub_addrb),
        .acc_addra       (acc_addra),
        .acc_addrb       (acc_addrb),
        .offmem_addra    (offmem_addra),
        .offmem_addrb    (offmem_addrb),
        .dout            (dout)
    );

    assign act_en = {read_ub, write_ub, read_acc, write_acc, data_fifo_en, mm_en, acc_en};

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input string sig, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("error %s %s: expected %0b actual %0b", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flags(input string name, input string sig, input logic [6:0] exp,
                               input logic [6:0] act);
        if (act !== exp) begin
            $display("error %s %s: expected %b actual %b", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_mode(input string name, input string sig, input axi_mode_e exp,
                              input axi_mode_e act);
        if (act !== exp) begin
            $display("error %s %s: expected %s actual %s", name, sig, exp.name(), act.name());
            test_errors++;
        end
    endtask

    task automatic check_ub_addr(input string name, input string sig, input ub_addr_t exp,
                                 input ub_addr_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h actual %h", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_acc_addr(input string name, input string sig, input acc_addr_t exp,
                                  input acc_addr_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h actual %h", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_offmem_addr(input string name, input string sig,
                                     input offmem_addr_t exp, input offmem_addr_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h actual %h", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_data(input string name, input string sig, input data_t exp,
                              input data_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h actual %h", name, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input string name);
        check_flags(name, "enables", exp_en, act_en);
        check_bit(name, "init_txn_pulse", exp_pulse, init_txn_pulse);
        check_bit(name, "inst_done", exp_done, inst_done);
        check_bit(name, "idle_flag", exp_idle, idle_flag);
        check_mode(name, "axi_sm_mode", exp_mode, axi_sm_mode);
        check_ub_addr(name, "ub_addra", exp_ub_addra, ub_addra);
        check_ub_addr(name, "ub_addrb", exp_ub_addrb, ub_addrb);
        check_acc_addr(name, "acc_addra", exp_acc_addra, acc_addra);
        check_acc_addr(name, "acc_addrb", exp_acc_addrb, acc_addrb);
        check_offmem_addr(name, "offmem_addra", exp_offmem_addra, offmem_addra);
        check_offmem_addr(name, "offmem_addrb", exp_offmem_addrb, offmem_addrb);
        check_data(name, "dout", exp_dout, dout);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic clear_expected(input logic done, input logic idle);
        exp_en           = '0;
        exp_pulse        = 1'b0;
        exp_done         = done;
        exp_idle         = idle;
        exp_mode         = AXI_IDLE;
        exp_ub_addra     = '0;
        exp_ub_addrb     = '0;
        exp_acc_addra    = '0;
        exp_acc_addrb    = '0;
        exp_offmem_addra = '0;
        exp_offmem_addrb = '0;
        exp_dout         = '0;
    endtask

    // Output pattern of one cycle while the instruction runs
    task automatic set_expected(input logic [3:0] op, input int phase, input logic txn_seen);
        clear_expected(1'b0, op == IDLE);
        case (op)
            DATA_FIFO: begin
                exp_en[EN_FIFO] = 1'b1;
            end
            UB_TO_DATA_FIFO: begin
                exp_en[EN_READ_UB] = 1'b1;
                exp_en[EN_FIFO]    = 1'b1;
                exp_ub_addrb       = cur_addrb[UB_ADDR_W-1:0];
            end
            MAT_MUL, MAT_MUL_ACC: begin
                exp_en[EN_ACC] = (op == MAT_MUL_ACC);
                if (phase == 0) begin
                    exp_en[EN_READ_UB] = 1'b1;
                    exp_ub_addrb       = cur_addrb[UB_ADDR_W-1:0];
                end else begin
                    exp_en[EN_WRITE_ACC] = 1'b1;
                    exp_en[EN_FIFO]      = 1'b1;
                    exp_en[EN_MM]        = 1'b1;
                    exp_acc_addra        = cur_addra[ACC_ADDR_W-1:0];
                end
            end
            ACC_TO_UB: begin
                if (phase == 0) begin
                    exp_en[EN_READ_ACC] = 1'b1;
                    exp_acc_addrb       = cur_addrb[ACC_ADDR_W-1:0];
                end else begin
                    exp_en[EN_WRITE_UB] = 1'b1;
                    exp_ub_addra        = cur_addra[UB_ADDR_W-1:0];
                    exp_dout            = cur_rin;
                end
            end
            AXI_TO_UB: begin
                exp_mode         = AXI_LOAD;
                exp_offmem_addrb = cur_addrb;
                exp_pulse        = (phase == 0);
                // Loaded word lands in the buffer in the txn_done cycle
                if (phase != 0 && txn_seen) begin
                    exp_en[EN_WRITE_UB] = 1'b1;
                    exp_ub_addra        = cur_addra[UB_ADDR_W-1:0];
                    exp_dout            = cur_din;
                end
            end
            UB_TO_AXI: begin
                if (phase == 0) begin
                    exp_en[EN_READ_UB] = 1'b1;
                    exp_ub_addrb       = cur_addrb[UB_ADDR_W-1:0];
                end else begin
                    exp_mode         = AXI_WRITE;
                    exp_offmem_addra = cur_addra;
                    exp_dout         = cur_uin;
                    exp_pulse        = (phase == 1);
                end
            end
            default: begin
                // No-op, nothing enabled
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic data_t random_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic string op_label(input logic [3:0] op);
        opcode_e code;
        code = opcode_e'(op);
        if (code.name() == "") begin
            return $sformatf("nop%0d", op);
        end
        return code.name();
    endfunction

    task automatic step_cycle(input logic [3:0] op, input int phase, input string name);
        @(negedge clk);
        set_expected(op, phase, txn_done);
        check_outputs(name);
    endtask

    // Wait step, outputs held until the responder answers
    task automatic wait_for_txn(input logic [3:0] op, input int phase, input string name);
        int waited;
        waited = 0;
        step_cycle(op, phase, name);
        while (txn_done !== 1'b1 && waited < TXN_MAX_DELAY) begin
            waited++;
            step_cycle(op, phase, name);
        end
        if (txn_done !== 1'b1) begin
            $display("%s: the wait step never saw txn_done within %0d cycles", name,
                     waited + 1);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d mismatches", name, test_errors);
        end
    endtask

    task automatic run_instruction(input int idx);
        logic [3:0] op;
        string      name;
        op          = 4'($random(seed));
        cur_addra   = $random(seed);
        cur_addrb   = $random(seed);
        cur_din     = random_word();
        cur_rin     = random_word();
        cur_uin     = random_word();
        name        = $sformatf("test_%0d_%s", idx, op_label(op));
        test_errors = 0;

        @(posedge clk);
        instruction     <= {op, cur_addra, cur_addrb};
        din             <= cur_din;
        rin             <= cur_rin;
        uin             <= cur_uin;
        init_inst_pulse <= 1'b1;
        // Edge not seen yet, previous state still holds
        @(negedge clk);
        check_outputs(name);
        @(posedge clk);
        init_inst_pulse <= 1'b0;

        case (op)
            AXI_TO_UB: begin
                step_cycle(op, 0, name);
                wait_for_txn(op, 1, name);
            end
            UB_TO_AXI: begin
                step_cycle(op, 0, name);
                step_cycle(op, 1, name);
                wait_for_txn(op, 2, name);
            end
            MAT_MUL, MAT_MUL_ACC, ACC_TO_UB: begin
                step_cycle(op, 0, name);
                step_cycle(op, 1, name);
            end
            default: begin
                step_cycle(op, 0, name);
            end
        endcase

        // Done and quiet
        @(negedge clk);
        clear_expected(1'b1, 1'b1);
        check_outputs(name);
        report_test(name);
    endtask

    // Off-memory responder
    initial begin : responder
        int delay;
        txn_done = 1'b0;
        forever begin
            @(negedge clk);
            if (init_txn_pulse === 1'b1) begin
                delay = 1 + int'($unsigned($random(seed)) % TXN_MAX_DELAY);
                repeat (delay) @(posedge clk);
                txn_done <= 1'b1;
                @(posedge clk);
                txn_done <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed            = 32'h556a;
        pass_count      = 0;
        fail_count      = 0;
        test_errors     = 0;
        reset_n         = 1'b0;
        instruction     = '0;
        init_inst_pulse = 1'b0;
        din             = '0;
        rin             = '0;
        uin             = '0;
        clear_expected(1'b0, 1'b1);
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // Nothing issued yet
        @(negedge clk);
        check_outputs("reset_state");
        report_test("reset_state");

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_instruction(i);
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
sa_ctrl_pkg.sv
cu_step_if.sv
cu_ctrl_if.sv
inst_sequencer.sv
local_op_ctrl.sv
offmem_xfer_ctrl.sv
cu_output_merge.sv
sa_control_unit.sv
tb_clk_gen.sv
sa_control_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the control unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module sa_control_unit_tb \
    && ./obj_dir/Vsa_control_unit_tb | tee /dev/stderr | grep -q "^STATUS: PASS$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
